//--- files.f
+incdir+src
src/bus_pkg.sv
src/menu_pkg.sv
src/key_debouncer.sv
src/write_bank.sv
src/menu_fsm.sv
src/config_sequencer.sv
src/board_ctrl_top.sv
test/board_ctrl_properties.sv
test/board_ctrl_tb.sv

//--- test/board_ctrl_tb.sv
`include "board_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_tb;

    localparam int MC       = `BC_MASTER_COUNT;
    localparam int DEPTH    = `BC_BANK_DEPTH;
    localparam int KEY_HOLD = 3 * `BC_DEBOUNCE_CYCLES;
    localparam int BEAT_W   = 3 + `BC_ADDR_WIDTH + `BC_DATA_WIDTH;

    logic clk, rstN, key_step_n, key_next_n;
    logic [17:0] sw;
    logic [MC-1:0] m_done;
    logic [3:0] status_led;
    bus_pkg::slave_id_t m_slave_id [MC];
    logic [MC-1:0] m_rd_wr, m_in_ex, m_burst;
    logic cfg_valid, cfg_first, cfg_last, m_go;
    bus_pkg::master_idx_t cfg_master;
    bus_pkg::addr_t cfg_addr;
    bus_pkg::word_t cfg_data;

    logic [31:0] lfsr_q = 32'h6695_b79a;
    int err_count = 0;
    int go_count  = 0;
    int cyc_n     = 0;
    int last_beat = -1;       // cycle of the previous beat or -1
    logic [BEAT_W-1:0] exp_q [$];
    logic [BEAT_W-1:0] obs_q [$];

    // switch choices for one round
    logic [1:0] sid [MC];
    logic [MC-1:0] rw, inex;
    bus_pkg::addr_t first [MC], count [MC], last [MC];
    bus_pkg::word_t typed [MC][DEPTH + 3];
    int n_typed [MC];

    board_ctrl_top u_dut (
        .clk, .rstN, .key_step_n, .key_next_n, .sw, .m_done, .status_led,
        .m_slave_id, .m_rd_wr, .m_in_ex, .m_burst, .cfg_valid, .cfg_master,
        .cfg_first, .cfg_last, .cfg_addr, .cfg_data, .m_go
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic logic [BEAT_W-1:0] pack_beat(input int m, input logic f, input logic l,
                                                    input bus_pkg::addr_t a,
                                                    input bus_pkg::word_t d);
        return {m[0], f, l, a, d};
    endfunction

    // depth of each slave, 0 for an idle master
    function automatic int slave_depth(input logic [1:0] id);
        case (id)
            2'd1: return `BC_SLAVE1_DEPTH;
            2'd2: return `BC_SLAVE2_DEPTH;
            2'd3: return `BC_SLAVE3_DEPTH;
            default: return 0;
        endcase
    endfunction

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            err_count++;
            $display("Error: %s expected %0h actual %0h", what, exp, act);
        end
    endtask

    task automatic press_key(input logic use_next);
        @(negedge clk);
        if (use_next) key_next_n = 1'b0;
        else key_step_n = 1'b0;
        repeat (KEY_HOLD) @(negedge clk);
        key_next_n = 1'b1;
        key_step_n = 1'b1;
        repeat (KEY_HOLD) @(negedge clk);
    endtask

    task automatic wait_led(input logic [3:0] want, input int limit, input string what);
        int n;
        n = 0;
        while (status_led !== want && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (status_led === want) else begin
            err_count++;
            $display("Timeout while %s, status LEDs stuck at %b instead of %b",
                     what, status_led, want);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rstN       = 1'b0;
        key_step_n = 1'b1;
        key_next_n = 1'b1;
        sw         = '0;
        m_done     = '0;
        repeat (10) @(negedge clk);
        last_beat = -1;
        exp_q.delete();
        obs_q.delete();
        rstN = 1'b1;
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        cyc_n++;
        if (rstN && cfg_valid) begin
            if (last_beat >= 0) check_eq("beat spacing", `BC_BEAT_CYCLES, cyc_n - last_beat);
            last_beat = cyc_n;
            obs_q.push_back(pack_beat(cfg_master, cfg_first, cfg_last, cfg_addr, cfg_data));
        end
        if (rstN && m_go) go_count++;
    end

    initial begin
        logic [MC-1:0] act;
        int span_i;
        int lim_i;
        int n_keep;

        rstN = 1'b0;
        key_step_n = 1'b1;
        key_next_n = 1'b1;
        sw = '0;
        m_done = '0;

        for (int r = 0; r < 8; r++) begin
            apply_reset();
            check_eq($sformatf("round %0d led after reset", r), 4'b0001, status_led);
            check_eq($sformatf("round %0d cfg_valid after reset", r), 0, cfg_valid);
            check_eq($sformatf("round %0d m_go after reset", r), 0, m_go);

            for (int m = 0; m < MC; m++) begin
                sid[m]     = rand_bits(2);
                first[m]   = rand_bits(`BC_ADDR_WIDTH);
                count[m]   = rand_bits(`BC_ADDR_WIDTH) >> 2;
                n_typed[m] = rand_bits(5) % (DEPTH + 4);
                if (rand_bits(2) == 0) count[m] = '0;   // no burst
            end
            rw   = rand_bits(MC);
            inex = rand_bits(MC);
            if (r % 4 == 1) begin
                sid[0]   = 2'd3;                         // top of the small slave
                first[0] = 12'd2047 - rand_bits(4);
            end
            if (r == 2) sid[1] = 2'd0;
            if (r == 6) begin
                sid[0] = 2'd0;
                sid[1] = 2'd0;
            end
            if (r == 3) begin
                inex = '1;
                if (sid[0] == 0) sid[0] = 2'd1;
                for (int m = 0; m < MC; m++) n_typed[m] = DEPTH + 3;
            end

            sw = '0;
            for (int m = 0; m < MC; m++) sw[2*m +: 2] = sid[m];
            press_key(1'b0);
            for (int m = 0; m < MC; m++) begin
                check_eq($sformatf("round %0d slave id m%0d", r, m), sid[m], m_slave_id[m]);
            end
            sw = '0;
            sw[MC-1:0] = rw;
            press_key(1'b0);
            check_eq($sformatf("round %0d rd_wr", r), rw, m_rd_wr);
            sw[MC-1:0] = inex;
            press_key(1'b0);
            check_eq($sformatf("round %0d in_ex", r), inex, m_in_ex);

            // typing phase for masters with in_ex in index order
            for (int m = 0; m < MC; m++) begin
                if (inex[m]) begin
                    for (int k = 0; k < n_typed[m]; k++) begin
                        typed[m][k] = rand_bits(16);
                        sw = {2'b00, typed[m][k]};
                        press_key(1'b1);
                    end
                    press_key(1'b0);
                end
            end

            for (int m = 0; m < MC; m++) begin
                sw = {6'd0, first[m]};
                press_key(1'b0);
                sw = {6'd0, count[m]};
                press_key(1'b0);
            end

            // expected stream
            act = '0;
            for (int m = 0; m < MC; m++) begin
                act[m] = (sid[m] != 0);
                if (act[m]) begin
                    // smaller of first plus count and the last address of the slave
                    span_i  = int'(first[m]) + int'(count[m]);
                    lim_i   = slave_depth(sid[m]) - 1;
                    last[m] = bus_pkg::addr_t'((span_i < lim_i) ? span_i : lim_i);
                    exp_q.push_back(pack_beat(m, 1'b1, 1'b0, first[m], '0));
                    n_keep = (n_typed[m] > DEPTH) ? DEPTH : n_typed[m];
                    if (inex[m]) begin
                        for (int k = 0; k < n_keep; k++) begin
                            exp_q.push_back(pack_beat(m, 1'b0, 1'b0,
                                                      bus_pkg::addr_t'(first[m] + k),
                                                      typed[m][k]));
                        end
                    end
                    exp_q.push_back(pack_beat(m, 1'b0, 1'b1, last[m], '0));
                end
            end

            wait_led(4'b0010, 400, "configuring");
            check_eq($sformatf("round %0d beat count", r), exp_q.size(), obs_q.size());
            for (int i = 0; i < exp_q.size() && i < obs_q.size(); i++) begin
                check_eq($sformatf("round %0d beat %0d", r, i), exp_q[i], obs_q[i]);
            end
            for (int m = 0; m < MC; m++) begin
                check_eq($sformatf("round %0d burst m%0d", r, m), count[m] != 0, m_burst[m]);
            end

            go_count = 0;
            press_key(1'b0);
            check_eq($sformatf("round %0d m_go pulses", r), 1, go_count);
            // done bits come in one at a time while the LEDs hold
            for (int m = 0; m < MC; m++) begin
                if (act[m]) begin
                    repeat (3) @(negedge clk);
                    check_eq($sformatf("round %0d led communicating", r), 4'b1000, status_led);
                    m_done[m] = 1'b1;
                end
            end
            wait_led(4'b0100, 20, "communicating");
        end

        $display("checks finished with %0d errors and %0d assertion failures",
                 err_count, u_dut.u_props.fail_count);
        if (err_count == 0 && u_dut.u_props.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/board_ctrl_properties.sv
`include "board_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_properties (
    input logic       clk,
    input logic       rstN,
    input logic       cfg_valid,
    input logic       cfg_first,
    input logic       cfg_last,
    input logic       m_go,
    input logic [3:0] status_led
);

    int fail_count = 0;   // read by the testbench at the end

    // beats are spaced by at least one idle cycle
    a_beat_gap: assert property (@(posedge clk) disable iff (!rstN) cfg_valid |=> !cfg_valid)
        else begin
            fail_count++;
            $error("cfg_valid high on two consecutive cycles");
        end

    a_go_pulse: assert property (@(posedge clk) disable iff (!rstN) m_go |=> !m_go)
        else begin
            fail_count++;
            $error("m_go held longer than one cycle");
        end

    a_mark_valid: assert property (@(posedge clk) disable iff (!rstN)
                                   (cfg_first || cfg_last) |-> cfg_valid)
        else begin
            fail_count++;
            $error("first or last flag without cfg_valid");
        end

    // menu starts in slave selection
    a_led_reset: assert property (@(posedge clk) $rose(rstN) |-> status_led == 4'b0001)
        else begin
            fail_count++;
            $error("status LEDs not 0001 right after reset");
        end

endmodule

bind board_ctrl_top board_ctrl_properties u_props (
    .clk, .rstN, .cfg_valid, .cfg_first, .cfg_last, .m_go, .status_led
);

`default_nettype wire

//--- src/board_ctrl_top.sv
`include "board_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_top (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        key_step_n,
    input  logic                        key_next_n,
    input  logic [17:0]                 sw,
    input  logic [`BC_MASTER_COUNT-1:0] m_done,
    output logic [3:0]                  status_led,
    output bus_pkg::slave_id_t          m_slave_id [`BC_MASTER_COUNT],
    output logic [`BC_MASTER_COUNT-1:0] m_rd_wr,
    output logic [`BC_MASTER_COUNT-1:0] m_in_ex,
    output logic [`BC_MASTER_COUNT-1:0] m_burst,
    output logic                        cfg_valid,
    output bus_pkg::master_idx_t        cfg_master,
    output logic                        cfg_first,
    output logic                        cfg_last,
    output bus_pkg::addr_t              cfg_addr,
    output bus_pkg::word_t              cfg_data,
    output logic                        m_go
);

    logic step_press, next_press, wr_en, cfg_start, go_req, cfg_done;
    menu_pkg::menu_state_t state;
    bus_pkg::master_idx_t wr_master, rd_master;
    bus_pkg::word_t wr_data, rd_word;
    bus_pkg::bank_idx_t rd_index;
    bus_pkg::bank_cnt_t word_count [`BC_MASTER_COUNT];
    bus_pkg::addr_t first_addr [`BC_MASTER_COUNT];
    bus_pkg::addr_t last_addr [`BC_MASTER_COUNT];
    logic [`BC_MASTER_COUNT-1:0] active;

    key_debouncer u_step_key (.clk, .rstN, .key_n(key_step_n), .press(step_press));
    key_debouncer u_next_key (.clk, .rstN, .key_n(key_next_n), .press(next_press));

    write_bank u_bank (
        .clk, .rstN, .wr_en, .wr_master, .wr_data,
        .rd_master, .rd_index, .rd_word, .word_count
    );

    menu_fsm u_menu (
        .clk, .rstN, .step_press, .next_press, .sw, .cfg_done, .m_done,
        .state, .wr_en, .wr_master, .wr_data, .cfg_start, .go_req,
        .first_addr, .last_addr, .m_slave_id, .m_rd_wr, .m_in_ex, .m_burst, .active
    );

    config_sequencer u_seq (
        .clk, .rstN, .cfg_start, .go_req, .first_addr, .last_addr,
        .in_ex(m_in_ex), .active, .word_count, .rd_word, .rd_master, .rd_index,
        .cfg_valid, .cfg_master, .cfg_first, .cfg_last, .cfg_addr, .cfg_data,
        .cfg_done, .m_go
    );

    // front panel phase LEDs
    always_comb begin
        case (state)
            menu_pkg::slave_sel:     status_led = 4'b0001;
            menu_pkg::com_ready:     status_led = 4'b0010;
            menu_pkg::communicating: status_led = 4'b1000;
            menu_pkg::com_done:      status_led = 4'b0100;
            default:                 status_led = 4'b0000;
        endcase
    end

endmodule

`default_nettype wire

//--- src/config_sequencer.sv
`include "board_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module config_sequencer (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        cfg_start,
    input  logic                        go_req,
    input  bus_pkg::addr_t              first_addr [`BC_MASTER_COUNT],
    input  bus_pkg::addr_t              last_addr [`BC_MASTER_COUNT],
    input  logic [`BC_MASTER_COUNT-1:0] in_ex,
    input  logic [`BC_MASTER_COUNT-1:0] active,
    input  bus_pkg::bank_cnt_t          word_count [`BC_MASTER_COUNT],
    input  bus_pkg::word_t              rd_word,
    output bus_pkg::master_idx_t        rd_master,
    output bus_pkg::bank_idx_t          rd_index,
    output logic                        cfg_valid,
    output bus_pkg::master_idx_t        cfg_master,
    output logic                        cfg_first,
    output logic                        cfg_last,
    output bus_pkg::addr_t              cfg_addr,
    output bus_pkg::word_t              cfg_data,
    output logic                        cfg_done,
    output logic                        m_go
);

    localparam int BW = $clog2(`BC_BEAT_CYCLES) + 1;

    menu_pkg::beat_state_t bs;
    bus_pkg::master_idx_t cur;
    bus_pkg::bank_cnt_t ptr;         // next word to send for cur
    logic [BW-1:0] cyc;
    logic beat_end, has_data, start_hdr, hdr_found;
    bus_pkg::master_idx_t hdr_idx;

    assign rd_master = cur;
    assign rd_index  = bus_pkg::bank_idx_t'(ptr);
    assign beat_end  = (bs != menu_pkg::idle) && (cyc == BW'(`BC_BEAT_CYCLES - 1));
    assign has_data  = in_ex[cur] && (ptr != word_count[cur]);
    assign start_hdr = (bs == menu_pkg::idle) ? cfg_start : (bs == menu_pkg::trailer && beat_end);

    // lowest active master, above cur once a stream is running
    always_comb begin
        hdr_found = 1'b0;
        hdr_idx   = '0;
        for (int i = `BC_MASTER_COUNT - 1; i >= 0; i--) begin
            if (active[i] && (bs == menu_pkg::idle || i > int'(cur))) begin
                hdr_found = 1'b1;
                hdr_idx   = bus_pkg::master_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bs <= menu_pkg::idle;
            {cur, ptr, cyc} <= '0;
            {cfg_valid, cfg_first, cfg_last, cfg_done, m_go} <= '0;
            {cfg_master, cfg_addr, cfg_data} <= '0;
        end else begin
            {cfg_valid, cfg_first, cfg_last, cfg_done} <= '0;
            m_go <= go_req;
            cyc  <= cyc + 1'b1;
            if (start_hdr) begin
                cyc <= '0;
                if (hdr_found) begin
                    bs         <= menu_pkg::header;
                    cur        <= hdr_idx;
                    ptr        <= '0;
                    cfg_valid  <= 1'b1;
                    cfg_first  <= 1'b1;
                    cfg_master <= hdr_idx;
                    cfg_addr   <= first_addr[hdr_idx];
                    cfg_data   <= '0;
                end else begin
                    bs       <= menu_pkg::idle;
                    cfg_done <= 1'b1;       // nothing more to send
                end
            end else if (beat_end) begin
                cyc        <= '0;
                cfg_valid  <= 1'b1;
                cfg_master <= cur;
                if (has_data) begin
                    bs       <= menu_pkg::data;
                    cfg_addr <= bus_pkg::addr_t'(first_addr[cur] + ptr);
                    cfg_data <= rd_word;
                    ptr      <= ptr + 1'b1;
                end else begin
                    bs       <= menu_pkg::trailer;
                    cfg_last <= 1'b1;
                    cfg_addr <= last_addr[cur];
                    cfg_data <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/menu_fsm.sv
`include "board_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module menu_fsm (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        step_press,
    input  logic                        next_press,
    input  logic [17:0]                 sw,
    input  logic                        cfg_done,
    input  logic [`BC_MASTER_COUNT-1:0] m_done,
    output menu_pkg::menu_state_t       state,
    output logic                        wr_en,
    output bus_pkg::master_idx_t        wr_master,
    output bus_pkg::word_t              wr_data,
    output logic                        cfg_start,
    output logic                        go_req,
    output bus_pkg::addr_t              first_addr [`BC_MASTER_COUNT],
    output bus_pkg::addr_t              last_addr [`BC_MASTER_COUNT],
    output bus_pkg::slave_id_t          m_slave_id [`BC_MASTER_COUNT],
    output logic [`BC_MASTER_COUNT-1:0] m_rd_wr,
    output logic [`BC_MASTER_COUNT-1:0] m_in_ex,
    output logic [`BC_MASTER_COUNT-1:0] m_burst,
    output logic [`BC_MASTER_COUNT-1:0] active
);

    localparam bus_pkg::master_idx_t LAST_MASTER = bus_pkg::master_idx_t'(`BC_MASTER_COUNT - 1);

    bus_pkg::master_idx_t midx;               // master being edited
    bus_pkg::addr_t lim;
    logic [`BC_ADDR_WIDTH:0] span_end;        // one extra bit, no wrap
    logic all_done;
    int nxt;

    // lowest set bit of v at or above from, -1 when none
    function automatic int next_set(input logic [`BC_MASTER_COUNT-1:0] v, input int from);
        int r;
        r = -1;
        for (int i = `BC_MASTER_COUNT - 1; i >= 0; i--) begin
            if (v[i] && i >= from) r = i;
        end
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < `BC_MASTER_COUNT; i++) begin
            active[i] = (m_slave_id[i] != '0);
        end
    end

    // ext_sel looks at the switches being captured, ext_write at the stored choice
    always_comb begin
        if (state == menu_pkg::ext_sel) begin
            nxt = next_set(sw[`BC_MASTER_COUNT-1:0], 0);
        end else begin
            nxt = next_set(m_in_ex, int'(midx) + 1);
        end
    end

    assign lim      = bus_pkg::slave_last_addr(m_slave_id[midx]);
    assign span_end = {1'b0, first_addr[midx]} + {1'b0, sw[`BC_ADDR_WIDTH-1:0]};
    assign all_done = &(m_done | ~active);   // idle masters never report

    assign wr_en     = (state == menu_pkg::ext_write) && next_press;
    assign wr_master = midx;
    assign wr_data   = sw[`BC_DATA_WIDTH-1:0];
    assign cfg_start = (state == menu_pkg::count_sel) && step_press && (midx == LAST_MASTER);
    assign go_req    = (state == menu_pkg::com_ready) && step_press;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= menu_pkg::slave_sel;
            midx       <= '0;
            m_slave_id <= '{default: '0};
            m_rd_wr    <= '0;
            m_in_ex    <= '0;
            m_burst    <= '0;
            first_addr <= '{default: '0};
            last_addr  <= '{default: '0};
        end else begin
            case (state)
                menu_pkg::slave_sel: if (step_press) begin
                    for (int i = 0; i < `BC_MASTER_COUNT; i++) begin
                        m_slave_id[i] <= sw[2*i +: 2];
                    end
                    state <= menu_pkg::rw_sel;
                end
                menu_pkg::rw_sel: if (step_press) begin
                    m_rd_wr <= sw[`BC_MASTER_COUNT-1:0];
                    state   <= menu_pkg::ext_sel;
                end
                menu_pkg::ext_sel, menu_pkg::ext_write: if (step_press) begin
                    if (state == menu_pkg::ext_sel) m_in_ex <= sw[`BC_MASTER_COUNT-1:0];
                    if (nxt >= 0) begin
                        state <= menu_pkg::ext_write;
                        midx  <= bus_pkg::master_idx_t'(nxt);
                    end else begin
                        state <= menu_pkg::first_addr_sel;
                        midx  <= '0;
                    end
                end
                menu_pkg::first_addr_sel: if (step_press) begin
                    first_addr[midx] <= sw[`BC_ADDR_WIDTH-1:0];
                    state            <= menu_pkg::count_sel;
                end
                menu_pkg::count_sel: if (step_press) begin
                    m_burst[midx] <= |sw[`BC_ADDR_WIDTH-1:0];
                    // clamp to the end of the chosen slave
                    last_addr[midx] <= (span_end > {1'b0, lim}) ? lim
                                                                : span_end[`BC_ADDR_WIDTH-1:0];
                    if (midx == LAST_MASTER) begin
                        state <= menu_pkg::configuring;
                    end else begin
                        midx  <= midx + 1'b1;
                        state <= menu_pkg::first_addr_sel;
                    end
                end
                menu_pkg::configuring: if (cfg_done) state <= menu_pkg::com_ready;
                menu_pkg::com_ready: if (step_press) state <= menu_pkg::communicating;
                menu_pkg::communicating: if (all_done) state <= menu_pkg::com_done;
                default: ;  // com_done waits for reset
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/write_bank.sv
`include "board_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module write_bank (
    input  logic                clk,
    input  logic                rstN,
    input  logic                wr_en,
    input  bus_pkg::master_idx_t wr_master,
    input  bus_pkg::word_t      wr_data,
    input  bus_pkg::master_idx_t rd_master,
    input  bus_pkg::bank_idx_t  rd_index,
    output bus_pkg::word_t      rd_word,
    output bus_pkg::bank_cnt_t  word_count [`BC_MASTER_COUNT]
);

    bus_pkg::word_t mem [`BC_MASTER_COUNT][`BC_BANK_DEPTH];
    logic wr_ok;

    // a full master drops further words
    assign wr_ok = wr_en && (word_count[wr_master] != bus_pkg::bank_cnt_t'(`BC_BANK_DEPTH));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            word_count <= '{default: '0};
        end else if (wr_ok) begin
            word_count[wr_master] <= word_count[wr_master] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_master][bus_pkg::bank_idx_t'(word_count[wr_master])] <= wr_data;
        end
    end

    assign rd_word = mem[rd_master][rd_index];  // async read for the sequencer

endmodule

`default_nettype wire

//--- src/key_debouncer.sv
`include "board_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module key_debouncer (
    input  logic clk,
    input  logic rstN,
    input  logic key_n,
    output logic press
);

    localparam int CW = $clog2(`BC_DEBOUNCE_CYCLES) + 1;

    logic [1:0] sync_q;      // two-stage synchronizer
    logic stable;            // debounced key level, 1 = released
    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sync_q <= 2'b11;
            stable <= 1'b1;
            cnt    <= '0;
            press  <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], key_n};
            press  <= 1'b0;
            if (sync_q[1] == stable) begin
                cnt <= '0;  // bounce, start over
            end else if (cnt == CW'(`BC_DEBOUNCE_CYCLES - 1)) begin
                cnt    <= '0;
                stable <= sync_q[1];
                press  <= stable;  // only a 1 -> 0 change is a press
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/menu_pkg.sv
`default_nettype none

package menu_pkg;

    // operator menu, stepped by the step key
    typedef enum logic [3:0] {
        slave_sel      = 4'd0,
        rw_sel         = 4'd1,
        ext_sel        = 4'd2,
        ext_write      = 4'd3,
        first_addr_sel = 4'd4,
        count_sel      = 4'd5,
        configuring    = 4'd6,
        com_ready      = 4'd7,
        communicating  = 4'd8,
        com_done       = 4'd9
    } menu_state_t;

    // kind of the last beat sent on the configuration stream
    typedef enum logic [1:0] {
        idle    = 2'd0,
        header  = 2'd1,
        data    = 2'd2,
        trailer = 2'd3
    } beat_state_t;

endpackage

`default_nettype wire

//--- src/bus_pkg.sv
`include "board_cfg.svh"
`default_nettype none

package bus_pkg;

    typedef logic [`BC_DATA_WIDTH-1:0] word_t;
    typedef logic [`BC_ADDR_WIDTH-1:0] addr_t;
    typedef logic [$clog2(`BC_SLAVE_COUNT + 1)-1:0] slave_id_t;   // 0 = master idle
    typedef logic [$clog2(`BC_BANK_DEPTH)-1:0] bank_idx_t;
    typedef logic [$clog2(`BC_BANK_DEPTH):0] bank_cnt_t;            // holds 0..BC_BANK_DEPTH
    typedef logic [$clog2(`BC_MASTER_COUNT)-1:0] master_idx_t;

    // highest address a slave answers to
    function automatic addr_t slave_last_addr(input slave_id_t id);
        case (id)
            2'd1: return addr_t'(`BC_SLAVE1_DEPTH - 1);
            2'd2: return addr_t'(`BC_SLAVE2_DEPTH - 1);
            2'd3: return addr_t'(`BC_SLAVE3_DEPTH - 1);
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/board_cfg.svh
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

`default_nettype none

// bus shape
`define BC_MASTER_COUNT     2
`define BC_SLAVE_COUNT      3
`define BC_DATA_WIDTH       16
`define BC_ADDR_WIDTH       12
`define BC_BANK_DEPTH       16   // typed words kept per master

// front panel timing, in clk cycles
`define BC_BEAT_CYCLES      2
`define BC_DEBOUNCE_CYCLES  8

`define BC_SLAVE1_DEPTH     4096
`define BC_SLAVE2_DEPTH     4096
`define BC_SLAVE3_DEPTH     2048

`default_nettype wire

`endif
